// ==== design/pipeline_tail_params.svh ====
`ifndef PIPELINE_TAIL_PARAMS_SVH
`define PIPELINE_TAIL_PARAMS_SVH

// Drawing buffer geometry, identical to the visible area
`define PT_H_ACTIVE 16
`define PT_V_ACTIVE 12
`define PT_BUF_WORDS (`PT_H_ACTIVE * `PT_V_ACTIVE)
`define PT_ADDR_W 8

// Horizontal timing in pixel clocks
`define PT_H_FRONT 2
`define PT_H_SYNC 3
`define PT_H_BACK 3
`define PT_H_TOTAL (`PT_H_ACTIVE + `PT_H_FRONT + `PT_H_SYNC + `PT_H_BACK)

// Vertical timing in lines
`define PT_V_FRONT 1
`define PT_V_SYNC 2
`define PT_V_BACK 1
`define PT_V_TOTAL (`PT_V_ACTIVE + `PT_V_FRONT + `PT_V_SYNC + `PT_V_BACK)

// Level of hsync and vsync during the pulse (0 is active low)
`define PT_SYNC_POL 0

`endif

// ==== design/pipeline_tail_pkg.sv ====
package pipeline_tail_pkg;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

    // Control word opcodes
    typedef enum logic [1:0] {
        OP_FILL      = 2'd0,
        OP_FRAME_END = 2'd1,
        OP_RSVD_2    = 2'd2,
        OP_RSVD_3    = 2'd3
    } pixel_op_t;

    // Kind bit 0 writes a single pixel
    typedef struct packed {
        logic       kind;
        logic [7:0] x;
        logic [6:0] y;
        color_t     color;
        logic [3:0] pad;
    } draw_word_t;

    // Kind bit 1 carries an opcode
    typedef struct packed {
        logic        kind;
        pixel_op_t   op;
        color_t      color;
        logic [16:0] pad;
    } ctrl_word_t;

    typedef union packed {
        draw_word_t draw;
        ctrl_word_t ctrl;
    } pixel_word_t;

endpackage

// ==== design/pixel_word_decoder.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module pixel_word_decoder (
    input  logic                           clk_display,
    input  logic                           rstn_display,
    input  logic                           pixel_valid,
    input  pipeline_tail_pkg::pixel_word_t pixel_word,
    input  logic                           writer_ready,
    output logic                           pixel_ready,
    output logic                           cmd_draw,
    output logic                           cmd_fill,
    output logic                           cmd_frame_end,
    output logic [`PT_ADDR_W-1:0]          cmd_addr,
    output pipeline_tail_pkg::color_t      cmd_color
);
    import pipeline_tail_pkg::*;

    logic accept;
    logic is_ctrl;
    logic in_range;
    logic slot_draw;
    logic slot_fill;
    logic slot_end;
    logic slot_full;

    // Kind bit sits at bit 31 in both views
    assign is_ctrl   = pixel_word.draw.kind;
    assign in_range  = (pixel_word.draw.x < `PT_H_ACTIVE) && (pixel_word.draw.y < `PT_V_ACTIVE);
    assign slot_full = slot_draw || slot_fill || slot_end;

    assign pixel_ready = writer_ready && !slot_full;
    assign accept      = pixel_valid && pixel_ready;

    // Held command is released only when the writer can take it
    assign cmd_draw      = slot_draw && writer_ready;
    assign cmd_fill      = slot_fill && writer_ready;
    assign cmd_frame_end = slot_end && writer_ready;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            slot_draw <= 1'b0;
            slot_fill <= 1'b0;
            slot_end  <= 1'b0;
        end else if (accept) begin
            // Off-screen draws and reserved opcodes leave the slot empty
            slot_draw <= !is_ctrl && in_range;
            slot_fill <= is_ctrl && (pixel_word.ctrl.op == OP_FILL);
            slot_end  <= is_ctrl && (pixel_word.ctrl.op == OP_FRAME_END);
        end else if (writer_ready) begin
            slot_draw <= 1'b0;
            slot_fill <= 1'b0;
            slot_end  <= 1'b0;
        end
    end

    always_ff @(posedge clk_display) begin
        if (accept) begin
            cmd_addr  <= `PT_ADDR_W'(pixel_word.draw.y * `PT_H_ACTIVE + pixel_word.draw.x);
            cmd_color <= is_ctrl ? pixel_word.ctrl.color : pixel_word.draw.color;
        end
    end

    // One command kind per pulse
    assert property (@(posedge clk_display) disable iff (!rstn_display)
        $onehot0({cmd_draw, cmd_fill, cmd_frame_end}));

endmodule

// ==== design/draw_writer.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module draw_writer (
    input  logic                      clk_display,
    input  logic                      rstn_display,
    input  logic                      cmd_draw,
    input  logic                      cmd_fill,
    input  logic                      cmd_frame_end,
    input  logic [`PT_ADDR_W-1:0]     cmd_addr,
    input  pipeline_tail_pkg::color_t cmd_color,
    input  logic                      swap_pulse,
    output logic                      writer_ready,
    output logic                      write_en,
    output logic [`PT_ADDR_W-1:0]     write_addr,
    output pipeline_tail_pkg::color_t write_data,
    output logic                      frame_done
);
    import pipeline_tail_pkg::*;

    localparam logic [1:0] ST_CLEAR     = 2'd0;
    localparam logic [1:0] ST_IDLE      = 2'd1;
    localparam logic [1:0] ST_FILL      = 2'd2;
    localparam logic [1:0] ST_WAIT_SWAP = 2'd3;

    logic [1:0]            state;
    logic [`PT_ADDR_W-1:0] fill_cnt;
    logic                  fill_last;
    color_t                fill_color;

    assign writer_ready = (state == ST_IDLE);
    assign fill_last    = (fill_cnt == `PT_ADDR_W'(`PT_BUF_WORDS - 1));

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            state      <= ST_CLEAR;
            fill_cnt   <= '0;
            write_en   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            write_en <= 1'b0;
            case (state)
                // Reset clear and colour fill share the address sweep
                ST_CLEAR, ST_FILL: begin
                    write_en <= 1'b1;
                    fill_cnt <= fill_last ? '0 : fill_cnt + 1'b1;
                    if (fill_last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    write_en <= cmd_draw;
                    if (cmd_fill) begin
                        state <= ST_FILL;
                    end else if (cmd_frame_end) begin
                        state      <= ST_WAIT_SWAP;
                        frame_done <= 1'b1;
                    end
                end
                default: begin
                    if (swap_pulse) begin
                        state      <= ST_IDLE;
                        frame_done <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_display) begin
        if (cmd_fill) begin
            fill_color <= cmd_color;
        end
        if (cmd_draw) begin
            write_addr <= cmd_addr;
            write_data <= cmd_color;
        end else if (state == ST_CLEAR || state == ST_FILL) begin
            write_addr <= fill_cnt;
            write_data <= (state == ST_CLEAR) ? '0 : fill_color;
        end
    end

    // Decoder keeps its command while the writer is busy
    assert property (@(posedge clk_display) disable iff (!rstn_display)
        (cmd_draw || cmd_fill || cmd_frame_end) |-> writer_ready);

endmodule

// ==== design/swap_controller.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module swap_controller (
    input  logic clk_display,
    input  logic rstn_display,
    input  logic vga_vsync,
    input  logic frame_done,
    output logic swap_pulse,
    output logic buffer_select
);
    localparam logic SYNC_ON = 1'(`PT_SYNC_POL);

    logic vsync_d;
    logic vsync_start;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vsync_d <= !SYNC_ON;
        end else begin
            vsync_d <= vga_vsync;
        end
    end

    // First cycle of the vertical sync pulse
    assign vsync_start = (vga_vsync == SYNC_ON) && (vsync_d != SYNC_ON);

    // Swap only once drawing of the back buffer has finished
    assign swap_pulse = vsync_start && frame_done;

    //////////////////////
    // Buffer select
    //////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            buffer_select <= 1'b0;
        end else if (swap_pulse) begin
            buffer_select <= !buffer_select;
        end
    end

    // The writer drops frame_done right after taking the swap
    assert property (@(posedge clk_display) disable iff (!rstn_display)
        swap_pulse |=> !frame_done);

endmodule

// ==== design/frame_buffer_pair.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module frame_buffer_pair (
    input  logic                      clk_display,
    input  logic                      buffer_select,
    input  logic                      view_back,
    input  logic                      write_en,
    input  logic [`PT_ADDR_W-1:0]     write_addr,
    input  pipeline_tail_pkg::color_t write_data,
    input  logic [`PT_ADDR_W-1:0]     read_addr,
    output pipeline_tail_pkg::color_t read_data
);
    import pipeline_tail_pkg::*;

    logic show_sel;
    logic show_sel_q;

    // Buffer index on screen, normally the one not being drawn
    assign show_sel = view_back ? buffer_select : !buffer_select;

    //////////////////////
    // Memories
    //////////////////////

    // Buffer 0 is A, written while buffer_select is 0
    for (genvar b = 0; b < 2; b++) begin : g_buf
        color_t mem [`PT_BUF_WORDS];
        color_t rd_q;

        // Both buffers start out black
        initial begin
            for (int i = 0; i < `PT_BUF_WORDS; i++) begin
                mem[i] = '0;
            end
        end

        always @(posedge clk_display) begin
            if (write_en && (buffer_select == 1'(b))) begin
                mem[write_addr] <= write_data;
            end
            rd_q <= mem[read_addr];
        end
    end

    // Select follows the data through the read stage
    always_ff @(posedge clk_display) begin
        show_sel_q <= show_sel;
    end

    assign read_data = show_sel_q ? g_buf[1].rd_q : g_buf[0].rd_q;

endmodule

// ==== design/vga_scanout.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module vga_scanout (
    input  logic                      clk_display,
    input  logic                      rstn_display,
    input  pipeline_tail_pkg::color_t read_data,
    output logic [`PT_ADDR_W-1:0]     read_addr,
    output logic                      vga_hsync,
    output logic                      vga_vsync,
    output logic [3:0]                vga_red,
    output logic [3:0]                vga_green,
    output logic [3:0]                vga_blue
);
    localparam int   H_W          = $clog2(`PT_H_TOTAL);
    localparam int   V_W          = $clog2(`PT_V_TOTAL);
    localparam int   H_SYNC_START = `PT_H_ACTIVE + `PT_H_FRONT;
    localparam int   H_SYNC_END   = H_SYNC_START + `PT_H_SYNC;
    localparam int   V_SYNC_START = `PT_V_ACTIVE + `PT_V_FRONT;
    localparam int   V_SYNC_END   = V_SYNC_START + `PT_V_SYNC;
    localparam logic SYNC_ON      = 1'(`PT_SYNC_POL);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_last;
    logic           v_last;
    logic           active;
    logic           hsync_now;
    logic           vsync_now;
    logic           active_d1;
    logic           hsync_d1;
    logic           vsync_d1;

    //////////////////////
    // Timing counters
    //////////////////////

    assign h_last = (h_cnt == H_W'(`PT_H_TOTAL - 1));
    assign v_last = (v_cnt == V_W'(`PT_V_TOTAL - 1));

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    assign active    = (h_cnt < H_W'(`PT_H_ACTIVE)) && (v_cnt < V_W'(`PT_V_ACTIVE));
    assign hsync_now = (h_cnt >= H_W'(H_SYNC_START)) && (h_cnt < H_W'(H_SYNC_END));
    assign vsync_now = (v_cnt >= V_W'(V_SYNC_START)) && (v_cnt < V_W'(V_SYNC_END));

    // Parked at address 0 during blanking
    assign read_addr = active ? `PT_ADDR_W'(v_cnt * `PT_H_ACTIVE + h_cnt) : '0;

    //////////////////////
    // Output pipeline
    //////////////////////

    // Stage 1 matches the memory read
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            active_d1 <= 1'b0;
            hsync_d1  <= 1'b0;
            vsync_d1  <= 1'b0;
        end else begin
            active_d1 <= active;
            hsync_d1  <= hsync_now;
            vsync_d1  <= vsync_now;
        end
    end

    // Stage 2 drives the pins
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vga_hsync <= !SYNC_ON;
            vga_vsync <= !SYNC_ON;
            vga_red   <= 4'd0;
            vga_green <= 4'd0;
            vga_blue  <= 4'd0;
        end else begin
            vga_hsync <= hsync_d1 ? SYNC_ON : !SYNC_ON;
            vga_vsync <= vsync_d1 ? SYNC_ON : !SYNC_ON;
            vga_red   <= active_d1 ? read_data.red : 4'd0;
            vga_green <= active_d1 ? read_data.green : 4'd0;
            vga_blue  <= active_d1 ? read_data.blue : 4'd0;
        end
    end

endmodule

// ==== design/pipeline_tail.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module pipeline_tail (
    input  logic                           clk_display,
    input  logic                           rstn_display,
    input  logic                           pixel_valid,
    input  pipeline_tail_pkg::pixel_word_t pixel_word,
    input  logic                           view_back,
    output logic                           pixel_ready,
    output logic                           vga_hsync,
    output logic                           vga_vsync,
    output logic [3:0]                     vga_red,
    output logic [3:0]                     vga_green,
    output logic [3:0]                     vga_blue
);
    import pipeline_tail_pkg::*;

    //////////////////////
    // Decode to execute
    //////////////////////
    logic                  writer_ready;
    logic                  cmd_draw;
    logic                  cmd_fill;
    logic                  cmd_frame_end;
    logic [`PT_ADDR_W-1:0] cmd_addr;
    color_t                cmd_color;

    //////////////////////
    // Execute to frame store
    //////////////////////
    logic                  write_en;
    logic [`PT_ADDR_W-1:0] write_addr;
    color_t                write_data;
    logic                  frame_done;
    logic                  swap_pulse;
    logic                  buffer_select;

    // Scanout read port
    logic [`PT_ADDR_W-1:0] read_addr;
    color_t                read_data;

    pixel_word_decoder pixel_word_decoder_i (
        .clk_display   (clk_display),
        .rstn_display  (rstn_display),
        .pixel_valid   (pixel_valid),
        .pixel_word    (pixel_word),
        .writer_ready  (writer_ready),
        .pixel_ready   (pixel_ready),
        .cmd_draw      (cmd_draw),
        .cmd_fill      (cmd_fill),
        .cmd_frame_end (cmd_frame_end),
        .cmd_addr      (cmd_addr),
        .cmd_color     (cmd_color)
    );

    draw_writer draw_writer_i (
        .clk_display   (clk_display),
        .rstn_display  (rstn_display),
        .cmd_draw      (cmd_draw),
        .cmd_fill      (cmd_fill),
        .cmd_frame_end (cmd_frame_end),
        .cmd_addr      (cmd_addr),
        .cmd_color     (cmd_color),
        .swap_pulse    (swap_pulse),
        .writer_ready  (writer_ready),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .frame_done    (frame_done)
    );

    swap_controller swap_controller_i (
        .clk_display   (clk_display),
        .rstn_display  (rstn_display),
        .vga_vsync     (vga_vsync),
        .frame_done    (frame_done),
        .swap_pulse    (swap_pulse),
        .buffer_select (buffer_select)
    );

    frame_buffer_pair frame_buffer_pair_i (
        .clk_display   (clk_display),
        .buffer_select (buffer_select),
        .view_back     (view_back),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .read_addr     (read_addr),
        .read_data     (read_data)
    );

    vga_scanout vga_scanout_i (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .read_data    (read_data),
        .read_addr    (read_addr),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

endmodule

// ==== sim/scanout_checker.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module scanout_checker (
    input  logic                           clk_display,
    input  logic                           rstn_display,
    input  logic                           pixel_valid,
    input  pipeline_tail_pkg::pixel_word_t pixel_word,
    input  logic                           view_back,
    input  logic                           pixel_ready,
    input  logic                           vga_hsync,
    input  logic                           vga_vsync,
    input  logic [3:0]                     vga_red,
    input  logic [3:0]                     vga_green,
    input  logic [3:0]                     vga_blue,
    output int                             error_count,
    output int                             accepted_count,
    output int                             swap_count
);
    import pipeline_tail_pkg::*;

    localparam int          H_SYNC_START = `PT_H_ACTIVE + `PT_H_FRONT;
    localparam int          V_SYNC_START = `PT_V_ACTIVE + `PT_V_FRONT;
    localparam logic        SYNC_ON      = 1'(`PT_SYNC_POL);
    localparam logic [13:0] IDLE_OUT     = {!SYNC_ON, !SYNC_ON, 12'd0};

    // Model of both buffers, index 0 is buffer A
    logic [11:0]           model_mem [2][`PT_BUF_WORDS];
    logic                  draw_sel;
    int                    cyc;
    int                    busy_until;
    logic                  end_pending;
    int                    end_cycle;
    int                    h_pos;
    int                    v_pos;
    logic                  prev_vsync;
    logic                  vs_start;
    logic                  ready_exp;
    // Expected {hsync, vsync, rgb}, one and two cycles ahead of the pins
    logic [13:0]           pipe1;
    logic [13:0]           pipe2;
    logic [13:0]           next_out;
    int                    errors;
    int                    accepted;
    int                    swaps;

    // Memory writes waiting for the edge they land on
    int                    wq_due [$];
    logic [`PT_ADDR_W-1:0] wq_addr [$];
    logic [11:0]           wq_data [$];

    assign error_count    = errors;
    assign accepted_count = accepted;
    assign swap_count     = swaps;

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic reset_model();
        model_mem   = '{default: '0};
        draw_sel    = 1'b0;
        cyc         = 0;
        busy_until  = `PT_BUF_WORDS;
        end_pending = 1'b0;
        end_cycle   = 0;
        h_pos       = 0;
        v_pos       = 0;
        prev_vsync  = !SYNC_ON;
        pipe1       = IDLE_OUT;
        pipe2       = IDLE_OUT;
        errors      = 0;
        accepted    = 0;
        swaps       = 0;
        wq_due.delete();
        wq_addr.delete();
        wq_data.delete();
    endtask

    task automatic queue_write(input int due, input int addr, input logic [11:0] data);
        wq_due.push_back(due);
        wq_addr.push_back(`PT_ADDR_W'(addr));
        wq_data.push_back(data);
    endtask

    //////////////////////
    // Word rules
    //////////////////////

    // Draw lands two edges after acceptance, fill sweeps from the third edge on
    task automatic apply_word(input pixel_word_t w);
        int i;
        if (!w.draw.kind) begin
            if (int'(w.draw.x) < `PT_H_ACTIVE && int'(w.draw.y) < `PT_V_ACTIVE) begin
                queue_write(cyc + 2, int'(w.draw.y) * `PT_H_ACTIVE + int'(w.draw.x),
                            w.draw.color);
                busy_until = cyc + 1;
            end
        end else if (w.ctrl.op == OP_FILL) begin
            for (i = 0; i < `PT_BUF_WORDS; i++) begin
                queue_write(cyc + 3 + i, i, w.ctrl.color);
            end
            busy_until = cyc + `PT_BUF_WORDS + 1;
        end else if (w.ctrl.op == OP_FRAME_END) begin
            end_pending = 1'b1;
            end_cycle   = cyc;
        end
    endtask

    task automatic commit_writes();
        while (wq_due.size() > 0 && wq_due[0] == cyc) begin
            model_mem[draw_sel][wq_addr[0]] = wq_data[0];
            void'(wq_due.pop_front());
            void'(wq_addr.pop_front());
            void'(wq_data.pop_front());
        end
    endtask

    //////////////////////
    // Scanout model
    //////////////////////

    function automatic logic [13:0] expected_outputs(input logic vb);
        logic        show;
        logic        hs;
        logic        vs;
        logic [11:0] rgb;
        show = vb ? draw_sel : !draw_sel;
        hs   = (h_pos >= H_SYNC_START && h_pos < H_SYNC_START + `PT_H_SYNC) ? SYNC_ON : !SYNC_ON;
        vs   = (v_pos >= V_SYNC_START && v_pos < V_SYNC_START + `PT_V_SYNC) ? SYNC_ON : !SYNC_ON;
        rgb  = 12'd0;
        if (h_pos < `PT_H_ACTIVE && v_pos < `PT_V_ACTIVE) begin
            rgb = model_mem[show][`PT_ADDR_W'(v_pos * `PT_H_ACTIVE + h_pos)];
        end
        return {hs, vs, rgb};
    endfunction

    task automatic compare_outputs();
        if (vga_hsync !== pipe2[13]) begin
            report_mismatch($sformatf("hsync got %b expected %b", vga_hsync, pipe2[13]));
        end
        if (vga_vsync !== pipe2[12]) begin
            report_mismatch($sformatf("vsync got %b expected %b", vga_vsync, pipe2[12]));
        end
        if ({vga_red, vga_green, vga_blue} !== pipe2[11:0]) begin
            report_mismatch($sformatf("RGB got %03h expected %03h",
                                      {vga_red, vga_green, vga_blue}, pipe2[11:0]));
        end
    endtask

    task automatic advance_counters();
        if (h_pos == `PT_H_TOTAL - 1) begin
            h_pos = 0;
            v_pos = (v_pos == `PT_V_TOTAL - 1) ? 0 : v_pos + 1;
        end else begin
            h_pos++;
        end
    endtask

    // Inputs change on the falling edge, registered outputs settle after the rising one
    always @(posedge clk_display) begin
        if (!rstn_display) begin
            reset_model();
        end else begin
            cyc++;
            compare_outputs();
            vs_start  = (pipe2[12] == SYNC_ON) && (prev_vsync != SYNC_ON);
            ready_exp = (cyc > busy_until) && !end_pending;
            if (pixel_ready !== ready_exp) begin
                report_mismatch($sformatf("pixel_ready got %b expected %b",
                                          pixel_ready, ready_exp));
            end
            next_out = expected_outputs(view_back);
            // Swap needs frame_done, which follows the frame end by one edge
            if (end_pending && vs_start && cyc >= end_cycle + 2) begin
                draw_sel    = !draw_sel;
                end_pending = 1'b0;
                swaps++;
            end
            if (pixel_valid && pixel_ready) begin
                accepted++;
                apply_word(pixel_word);
            end
            commit_writes();
            prev_vsync = pipe2[12];
            pipe2      = pipe1;
            pipe1      = next_out;
            advance_counters();
        end
    end

endmodule

// ==== sim/tb_pipeline_tail.sv ====
`timescale 1ns/1ps
`include "pipeline_tail_params.svh"

module tb_pipeline_tail;
    import pipeline_tail_pkg::*;

    localparam int          CLK_PERIOD      = 4;
    localparam int          RESET_CYCLES    = 8;
    localparam int          NUM_FRAMES      = 20;
    localparam int          FRAME_CLOCKS    = `PT_H_TOTAL * `PT_V_TOTAL;
    localparam int          WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CLOCKS * 3 + `PT_BUF_WORDS
                                              + RESET_CYCLES;
    localparam int unsigned SEED            = 32'hca91;

    logic        clk_display = 1'b0;
    logic        rstn_display;
    logic        pixel_valid;
    pixel_word_t pixel_word;
    logic        view_back;
    logic        pixel_ready;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [3:0]  vga_red;
    logic [3:0]  vga_green;
    logic [3:0]  vga_blue;
    int          error_count;
    int          accepted_count;
    int          swap_count;
    int          sent_count;
    int          count_errors;

    always #(CLK_PERIOD / 2) clk_display = !clk_display;

    pipeline_tail pipeline_tail_i (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pixel_valid  (pixel_valid),
        .pixel_word   (pixel_word),
        .view_back    (view_back),
        .pixel_ready  (pixel_ready),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

    scanout_checker scanout_checker_i (
        .clk_display    (clk_display),
        .rstn_display   (rstn_display),
        .pixel_valid    (pixel_valid),
        .pixel_word     (pixel_word),
        .view_back      (view_back),
        .pixel_ready    (pixel_ready),
        .vga_hsync      (vga_hsync),
        .vga_vsync      (vga_vsync),
        .vga_red        (vga_red),
        .vga_green      (vga_green),
        .vga_blue       (vga_blue),
        .error_count    (error_count),
        .accepted_count (accepted_count),
        .swap_count     (swap_count)
    );

    //////////////////////
    // Word generation
    //////////////////////

    // One draw in ten lands off screen in x or in y
    function automatic pixel_word_t random_draw();
        pixel_word_t w;
        w            = '0;
        w.draw.color = 12'($urandom_range(12'hfff));
        w.draw.x     = 8'($urandom_range(`PT_H_ACTIVE - 1));
        w.draw.y     = 7'($urandom_range(`PT_V_ACTIVE - 1));
        if ($urandom_range(9) == 0) begin
            if ($urandom_range(1) == 1) begin
                w.draw.x = 8'($urandom_range(255, `PT_H_ACTIVE));
            end else begin
                w.draw.y = 7'($urandom_range(127, `PT_V_ACTIVE));
            end
        end
        return w;
    endfunction

    function automatic pixel_word_t ctrl_word(input pixel_op_t op);
        pixel_word_t w;
        w            = '0;
        w.ctrl.kind  = 1'b1;
        w.ctrl.op    = op;
        w.ctrl.color = 12'($urandom_range(12'hfff));
        return w;
    endfunction

    function automatic logic shows_back_buffer(input int frame);
        return (frame == 3) || (frame == 9) || (frame == 16);
    endfunction

    // Random idle cycles before the word is held until pixel_ready takes it
    task automatic send_word(input pixel_word_t w);
        logic taken;
        taken = 1'b0;
        while ($urandom_range(3) == 0) begin
            pixel_valid = 1'b0;
            @(negedge clk_display);
        end
        pixel_valid = 1'b1;
        pixel_word  = w;
        sent_count++;
        while (!taken) begin
            taken = pixel_ready;
            @(negedge clk_display);
        end
        pixel_valid = 1'b0;
    endtask

    task automatic send_frame();
        int n_draws;
        int i;
        n_draws = $urandom_range(60, 30);
        if ($urandom_range(9) < 3) begin
            send_word(ctrl_word(OP_FILL));
        end
        for (i = 0; i < n_draws; i++) begin
            send_word(random_draw());
        end
        send_word(ctrl_word(OP_FRAME_END));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock cycles, the DUT stopped taking words",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int frame;
        void'($urandom(SEED));
        rstn_display = 1'b0;
        pixel_valid  = 1'b0;
        pixel_word   = '0;
        view_back    = 1'b0;
        sent_count   = 0;
        count_errors = 0;
        repeat (RESET_CYCLES) @(negedge clk_display);
        rstn_display = 1'b1;

        for (frame = 0; frame < NUM_FRAMES; frame++) begin
            view_back = shows_back_buffer(frame);
            send_frame();
        end

        // Wait for the last swap and scan out one more frame
        while (!pixel_ready) begin
            @(negedge clk_display);
        end
        view_back = 1'b0;
        repeat (FRAME_CLOCKS) @(negedge clk_display);

        if (accepted_count != sent_count) begin
            $display("Word count wrong: %0d words offered but %0d accepted",
                     sent_count, accepted_count);
            count_errors++;
        end
        if (swap_count != NUM_FRAMES) begin
            $display("Swap count wrong: %0d frames sent but %0d buffer swaps",
                     NUM_FRAMES, swap_count);
            count_errors++;
        end
        $display(
            "Report: %0d offered, %0d accepted, %0d swaps, %0d mismatches, %0d count errors",
            sent_count, accepted_count, swap_count, error_count, count_errors);
        if (error_count + count_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/pipeline_tail_pkg.sv
design/pixel_word_decoder.sv
design/draw_writer.sv
design/swap_controller.sv
design/frame_buffer_pair.sv
design/vga_scanout.sv
design/pipeline_tail.sv
sim/scanout_checker.sv
sim/tb_pipeline_tail.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_pipeline_tail -o tb_pipeline_tail -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_pipeline_tail)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
